//--- verilog/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;     // data, address, instruction
  typedef logic [4:0]  reg_idx_t;  // register number
  typedef logic [1:0]  alu_op_t;   // alu control class or alu operation
  typedef logic [1:0]  fwd_sel_t;  // operand source select

  // rv32i major opcodes
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 of the supported r-type ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // funct7 bit picks sub
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // control class from decode
  localparam alu_op_t CTL_ADD   = 2'b00;  // lw, sw, addi
  localparam alu_op_t CTL_FUNCT = 2'b10;  // r-type, look at funct bits

  // resolved alu operation in execute
  localparam alu_op_t ALU_ADD = 2'd0;
  localparam alu_op_t ALU_SUB = 2'd1;
  localparam alu_op_t ALU_AND = 2'd2;
  localparam alu_op_t ALU_OR  = 2'd3;

  localparam fwd_sel_t FWD_REG = 2'd0;  // value read in decode
  localparam fwd_sel_t FWD_EXM = 2'd1;  // ex/mem alu_out
  localparam fwd_sel_t FWD_WB  = 2'd2;  // mem/wb result

  localparam reg_idx_t ECALL_REG = 5'd17;   // a7 holds the service code
  localparam word_t    HALT_CODE = 32'd10;  // exit service

  typedef struct packed {
    logic     valid;
    logic     alu_src;     // second operand is imm
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     halt;        // halting ecall
    alu_op_t  alu_op;
    logic [2:0] funct3;
    logic     funct7_b;    // inst[30]
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     halt;
    word_t    alu_out;     // result or memory address
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;       // a register result is on the bus
    logic     reg_write;
    logic     halt;        // sticky once the exit ecall retires
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
  parameter int IMEM_WORDS = 64
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           stall,      // load-use or ecall dependence
  input  logic           hold,       // halt seen, fetch frozen
  input  logic           prog_we,
  input  cpu_pkg::word_t prog_addr,  // word index
  input  cpu_pkg::word_t prog_data,
  output cpu_pkg::word_t if_inst,
  output logic           if_valid
);
  import cpu_pkg::*;

  localparam int IW = $clog2(IMEM_WORDS);

  word_t imem [IMEM_WORDS];
  word_t pc;
  word_t fetch_word;
  logic  advance;

  assign fetch_word = imem[pc[IW+1:2]];  // async read, byte pc to word index
  assign advance    = !stall && !hold;

  // program load port, only driven while reset is high
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr[IW-1:0]] <= prog_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (advance) begin
      pc       <= pc + 32'd4;
      if_valid <= 1'b1;  // first fetch after reset
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if_inst <= fetch_word;  // if/id holds on stall
    end
  end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::reg_idx_t dbg_addr,
  input  cpu_pkg::wb_t      wb,
  output cpu_pkg::word_t    rs1_data,
  output cpu_pkg::word_t    rs2_data,
  output cpu_pkg::word_t    dbg_data
);
  import cpu_pkg::*;

  word_t regs [32];
  logic  wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);  // x0 never written

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // same-cycle write is visible to decode
  assign rs1_data = (wr_en && (wb.rd == rs1)) ? wb.data : regs[rs1];
  assign rs2_data = (wr_en && (wb.rd == rs2)) ? wb.data : regs[rs2];
  assign dbg_data = regs[dbg_addr];  // testbench peek, no bypass

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::word_t    if_inst,
  input  logic              if_valid,
  input  logic              stall,
  input  logic              fwd_dec_rs1,     // take x17 from ex/mem
  input  cpu_pkg::word_t    rs1_data,
  input  cpu_pkg::word_t    rs2_data,
  input  cpu_pkg::word_t    ex_mem_alu_out,
  output cpu_pkg::reg_idx_t rs1,
  output cpu_pkg::reg_idx_t rs2,
  output logic              is_ecall,
  output logic              halt_seen,
  output cpu_pkg::id_ex_t   id_ex
);
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic       dec_valid;
  logic       is_r;
  logic       is_imm;
  logic       is_load;
  logic       is_store;
  reg_idx_t   rd;
  word_t      imm;
  word_t      rs1_val;
  logic       halt_now;
  logic       bubble;
  id_ex_t     id_ex_d;

  assign opcode    = if_inst[6:0];
  assign dec_valid = if_valid && !halt_seen;  // nothing past the exit ecall
  assign is_r      = (opcode == OP_R);
  assign is_imm    = (opcode == OP_IMM);
  assign is_load   = (opcode == OP_LOAD);
  assign is_store  = (opcode == OP_STORE);
  assign is_ecall  = dec_valid && (opcode == OP_SYSTEM);
  assign rd        = if_inst[11:7];

  // ecall reads a7 through the rs1 port
  assign rs1 = !dec_valid ? '0 : (is_ecall ? ECALL_REG : if_inst[19:15]);
  // i-type has imm bits in the rs2 field, keep them out of the hazard check
  assign rs2 = (dec_valid && (is_r || is_store)) ? if_inst[24:20] : '0;

  assign imm = is_store ? {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]}
                        : {{20{if_inst[31]}}, if_inst[31:20]};

  assign rs1_val  = fwd_dec_rs1 ? ex_mem_alu_out : rs1_data;  // wb bypass is in reg_file
  assign halt_now = is_ecall && (rs1_val == HALT_CODE);
  assign bubble   = stall || !dec_valid;

  always_comb begin
    id_ex_d       = '0;
    id_ex_d.valid = !bubble;
    if (!bubble) begin
      id_ex_d.alu_src    = is_imm || is_load || is_store;
      id_ex_d.mem_read   = is_load;
      id_ex_d.mem_write  = is_store;
      id_ex_d.mem_to_reg = is_load;
      id_ex_d.reg_write  = (is_r || is_imm || is_load) && (rd != '0);  // x0 writes dropped
      id_ex_d.halt       = halt_now;
    end
    id_ex_d.alu_op   = is_r ? CTL_FUNCT : CTL_ADD;
    id_ex_d.funct3   = if_inst[14:12];
    id_ex_d.funct7_b = if_inst[30];
    id_ex_d.rs1      = rs1;
    id_ex_d.rs2      = rs2;
    id_ex_d.rs1_data = rs1_val;
    id_ex_d.rs2_data = rs2_data;
    id_ex_d.imm      = imm;
    id_ex_d.rd       = rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_seen <= 1'b0;
    end else if (halt_now && !stall) begin
      halt_seen <= 1'b1;  // set only once the ecall really issues
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid      <= 1'b0;
      id_ex.alu_src    <= 1'b0;
      id_ex.mem_read   <= 1'b0;
      id_ex.mem_write  <= 1'b0;
      id_ex.mem_to_reg <= 1'b0;
      id_ex.reg_write  <= 1'b0;
      id_ex.halt       <= 1'b0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
  input  cpu_pkg::reg_idx_t rs1,       // decode sources
  input  cpu_pkg::reg_idx_t rs2,
  input  logic              is_ecall,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::ex_mem_t  ex_mem,
  input  cpu_pkg::wb_t      wb,
  output logic              stall,
  output cpu_pkg::fwd_sel_t fwd_a,
  output cpu_pkg::fwd_sel_t fwd_b,
  output logic              fwd_dec_rs1
);
  import cpu_pkg::*;

  logic load_use;
  logic ecall_dep_ex;
  logic ecall_dep_mem;

  // younger producer wins, x0 never matches
  function automatic fwd_sel_t pick_src(reg_idx_t src, ex_mem_t em, wb_t w);
    if ((src != '0) && em.valid && em.reg_write && (em.rd == src)) return FWD_EXM;
    if ((src != '0) && w.valid && w.reg_write && (w.rd == src)) return FWD_WB;
    return FWD_REG;
  endfunction

  assign load_use = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) &&
                    ((id_ex.rd == rs1) || (id_ex.rd == rs2));

  // the x17 compare sits in decode, no result from execute is ready yet
  assign ecall_dep_ex = is_ecall && id_ex.valid && id_ex.reg_write && (id_ex.rd == rs1);
  // load data only shows up at mem/wb
  assign ecall_dep_mem = is_ecall && ex_mem.valid && ex_mem.mem_read &&
                         ex_mem.reg_write && (ex_mem.rd == rs1);

  assign stall = load_use || ecall_dep_ex || ecall_dep_mem;

  assign fwd_dec_rs1 = is_ecall && ex_mem.valid && ex_mem.reg_write &&
                       !ex_mem.mem_read && (ex_mem.rd == rs1) && (rs1 != '0);

  assign fwd_a = pick_src(id_ex.rs1, ex_mem, wb);
  assign fwd_b = pick_src(id_ex.rs2, ex_mem, wb);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::fwd_sel_t fwd_a,
  input  cpu_pkg::fwd_sel_t fwd_b,
  input  cpu_pkg::wb_t      wb,
  output cpu_pkg::ex_mem_t  ex_mem
);
  import cpu_pkg::*;

  word_t   opnd_a;
  word_t   fwd_b_val;  // also the store data
  word_t   opnd_b;
  word_t   alu_res;
  alu_op_t alu_sel;
  ex_mem_t ex_mem_d;

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t exm_val,
                                    word_t wb_val);
    case (sel)
      FWD_EXM: return exm_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign opnd_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_out, wb.data);
  assign fwd_b_val = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_out, wb.data);
  assign opnd_b    = id_ex.alu_src ? id_ex.imm : fwd_b_val;

  // alu control
  always_comb begin
    alu_sel = ALU_ADD;  // address calc and addi
    if (id_ex.alu_op == CTL_FUNCT) begin
      case (id_ex.funct3)
        F3_ADD_SUB: alu_sel = id_ex.funct7_b ? ALU_SUB : ALU_ADD;
        F3_AND:     alu_sel = ALU_AND;
        F3_OR:      alu_sel = ALU_OR;
        default:    alu_sel = ALU_ADD;
      endcase
    end
  end

  always_comb begin
    case (alu_sel)
      ALU_SUB: alu_res = opnd_a - opnd_b;
      ALU_AND: alu_res = opnd_a & opnd_b;
      ALU_OR:  alu_res = opnd_a | opnd_b;
      default: alu_res = opnd_a + opnd_b;
    endcase
  end

  always_comb begin
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.mem_read   = id_ex.mem_read;
    ex_mem_d.mem_write  = id_ex.mem_write;
    ex_mem_d.mem_to_reg = id_ex.mem_to_reg;
    ex_mem_d.reg_write  = id_ex.reg_write;
    ex_mem_d.halt       = id_ex.halt;
    ex_mem_d.alu_out    = alu_res;
    ex_mem_d.store_data = fwd_b_val;
    ex_mem_d.rd         = id_ex.rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid      <= 1'b0;
      ex_mem.mem_read   <= 1'b0;
      ex_mem.mem_write  <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.reg_write  <= 1'b0;
      ex_mem.halt       <= 1'b0;
    end else begin
      ex_mem <= ex_mem_d;
    end
  end

endmodule

//--- verilog/mem_stage.sv
`timescale 1ns/100ps

module mem_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::ex_mem_t ex_mem,
  output cpu_pkg::wb_t     wb
);
  import cpu_pkg::*;

  localparam int DW = $clog2(DMEM_WORDS);

  word_t         dmem [DMEM_WORDS];
  logic [DW-1:0] dmem_idx;
  word_t         load_data;
  logic          mw_valid;
  logic          mw_reg_write;
  logic          mw_mem_to_reg;
  logic          halted_q;
  reg_idx_t      mw_rd;
  word_t         mw_alu;
  word_t         mw_load;

  assign dmem_idx  = ex_mem.alu_out[DW+1:2];  // word access only
  assign load_data = dmem[dmem_idx];          // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.valid && ex_mem.mem_write) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  // mem/wb control
  always_ff @(posedge clk) begin
    if (reset) begin
      mw_valid      <= 1'b0;
      mw_reg_write  <= 1'b0;
      mw_mem_to_reg <= 1'b0;
      halted_q      <= 1'b0;
    end else begin
      mw_valid      <= ex_mem.valid && ex_mem.reg_write;  // stores, ecalls stay quiet
      mw_reg_write  <= ex_mem.reg_write;
      mw_mem_to_reg <= ex_mem.mem_to_reg;
      halted_q      <= halted_q || (ex_mem.valid && ex_mem.halt);  // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    mw_rd   <= ex_mem.rd;
    mw_alu  <= ex_mem.alu_out;
    mw_load <= load_data;
  end

  always_comb begin
    wb.valid     = mw_valid;
    wb.reg_write = mw_reg_write;
    wb.halt      = halted_q;
    wb.rd        = mw_rd;
    wb.data      = mw_mem_to_reg ? mw_load : mw_alu;  // writeback mux
  end

endmodule

//--- verilog/pipelined_cpu.sv
`timescale 1ns/100ps

module pipelined_cpu #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              prog_we,    // load port, used during reset
  input  cpu_pkg::word_t    prog_addr,
  input  cpu_pkg::word_t    prog_data,
  input  cpu_pkg::reg_idx_t dbg_addr,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_rd,
  output cpu_pkg::word_t    wb_data,
  output cpu_pkg::word_t    dbg_data,
  output logic              halted
);
  import cpu_pkg::*;

  word_t    if_inst;
  logic     if_valid;
  logic     stall;
  logic     halt_seen;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     is_ecall;
  logic     fwd_dec_rs1;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  wb_t      wb;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .clk, .reset, .stall,
    .hold      (halt_seen),
    .prog_we, .prog_addr, .prog_data,
    .if_inst, .if_valid
  );

  reg_file u_reg_file (
    .clk, .reset, .rs1, .rs2, .dbg_addr, .wb,
    .rs1_data, .rs2_data, .dbg_data
  );

  decode_stage u_decode (
    .clk, .reset, .if_inst, .if_valid, .stall, .fwd_dec_rs1,
    .rs1_data, .rs2_data,
    .ex_mem_alu_out (ex_mem.alu_out),
    .rs1, .rs2, .is_ecall, .halt_seen, .id_ex
  );

  hazard_unit u_hazard (
    .rs1, .rs2, .is_ecall, .id_ex, .ex_mem, .wb,
    .stall, .fwd_a, .fwd_b, .fwd_dec_rs1
  );

  execute_stage u_execute (
    .clk, .reset, .id_ex, .fwd_a, .fwd_b, .wb, .ex_mem
  );

  mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
    .clk, .reset, .ex_mem, .wb
  );

  // observation outputs straight off the wb bus
  assign wb_valid = wb.valid;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;
  assign halted   = wb.halt;

endmodule

//--- verif/tb_pipelined_cpu.sv
`timescale 1ns/100ps

module tb_pipelined_cpu;
  import cpu_pkg::*;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 64;

  logic     clk;
  logic     reset;
  logic     prog_we;
  word_t    prog_addr;
  word_t    prog_data;
  reg_idx_t dbg_addr;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;
  word_t    dbg_data;
  logic     halted;

  // expected values from the data file
  word_t    prog_q[$];
  reg_idx_t wb_rd_q[$];
  word_t    wb_data_q[$];
  reg_idx_t reg_idx_q[$];
  word_t    reg_val_q[$];

  int   wb_seen;      // writeback pulses matched so far
  int   cycle_cnt;    // cycles since reset release
  int   cycle_limit;
  logic running;

  pipelined_cpu #(
    .IMEM_WORDS (IMEM_WORDS),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_pipelined_cpu (
    .clk, .reset, .prog_we, .prog_addr, .prog_data, .dbg_addr,
    .wb_valid, .wb_rd, .wb_data, .dbg_data, .halted
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_wb(input reg_idx_t exp_rd, input word_t exp_data);
    if (wb_rd !== exp_rd) begin
      $display("Fail at %0t: wb_rd expected %0d, got %0d", $time, exp_rd, wb_rd);
      abort_run();
    end
    if (wb_data !== exp_data) begin
      $display("Fail at %0t: wb_data (x%0d) expected %h, got %h",
               $time, exp_rd, exp_data, wb_data);
      abort_run();
    end
  endtask

  task automatic check_reg(input reg_idx_t idx, input word_t exp_val);
    if (dbg_data !== exp_val) begin
      $display("Fail at %0t: dbg_data (x%0d) expected %h, got %h",
               $time, idx, exp_val, dbg_data);
      abort_run();
    end
  endtask

  task automatic check_halt(input logic exp_halt);
    if (halted !== exp_halt) begin
      $display("Fail at %0t: halted expected %b, got %b", $time, exp_halt, halted);
      abort_run();
    end
  endtask

  // tagged lines, '#' starts a comment up to end of line
  task automatic read_input_file();
    int              fd;
    int              code;
    int              idx;
    logic [7:0]      tag;
    word_t           val;
    logic [8*128-1:0] rest;
    fd = $fopen("verif/program_input.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open verif/program_input.txt");
      abort_run();
    end
    while (1) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) break;  // end of file
      if (tag == "#") begin
        code = $fgets(rest, fd);  // drop comment text
      end else if (tag == "I") begin
        code = $fscanf(fd, "%h", val);
        if (code != 1) begin
          $display("Error: malformed I line in program_input.txt");
          abort_run();
        end
        prog_q.push_back(val);
      end else if ((tag == "W") || (tag == "R")) begin
        code = $fscanf(fd, "%d %h", idx, val);
        if ((code != 2) || (idx < 0) || (idx > 31)) begin
          $display("Error: malformed %s line in program_input.txt", tag);
          abort_run();
        end
        if (tag == "W") begin
          wb_rd_q.push_back(reg_idx_t'(idx));
          wb_data_q.push_back(val);
        end else begin
          reg_idx_q.push_back(reg_idx_t'(idx));
          reg_val_q.push_back(val);
        end
      end else begin
        $display("Error: unknown tag '%s' in program_input.txt", tag);
        abort_run();
      end
    end
    $fclose(fd);
    if ((prog_q.size() == 0) || (prog_q.size() > IMEM_WORDS)) begin
      $display("Error: program has %0d words, memory holds %0d", prog_q.size(), IMEM_WORDS);
      abort_run();
    end
  endtask

  // load port writes, one word per cycle while reset is high
  task automatic load_program();
    for (int i = 0; i < prog_q.size(); i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = word_t'(i);  // word index
      prog_data = prog_q[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  // writeback monitor, outputs settled mid-cycle
  always @(negedge clk) begin
    if (!reset && (wb_valid === 1'b1)) begin
      if (wb_seen >= wb_rd_q.size()) begin
        $display("Error at %0t: extra writeback to x%0d after the expected sequence",
                 $time, wb_rd);
        abort_run();
      end
      check_wb(wb_rd_q[wb_seen], wb_data_q[wb_seen]);
      wb_seen++;
    end
  end

  // timeout
  always @(negedge clk) begin
    if (running) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        if (halted !== 1'b1) begin
          $display("Error: processor never halted within %0d cycles", cycle_limit);
        end else begin
          $display("Error: final checks did not finish within %0d cycles", cycle_limit);
        end
        abort_run();
      end
    end
  end

  initial begin
    reset     = 1'b1;  // held through the load phase
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_addr  = '0;
    wb_seen   = 0;
    cycle_cnt = 0;
    running   = 1'b0;

    read_input_file();
    cycle_limit = 8 * prog_q.size() + 50;
    load_program();
    repeat (2) @(negedge clk);  // two more reset cycles
    check_halt(1'b0);
    reset   = 1'b0;
    running = 1'b1;

    while (halted !== 1'b1) begin
      @(negedge clk);
    end

    // let the pipe drain, nothing younger may retire
    repeat (4) @(negedge clk);
    #10;
    check_halt(1'b1);  // sticky
    if (wb_seen != wb_rd_q.size()) begin
      $display("Error: %0d writebacks seen, %0d expected", wb_seen, wb_rd_q.size());
      abort_run();
    end

    // final register file through the debug port
    for (int i = 0; i < reg_idx_q.size(); i++) begin
      @(negedge clk);
      dbg_addr = reg_idx_q[i];
      #10;
      check_reg(reg_idx_q[i], reg_val_q[i]);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verif/program_input.txt
# I <word hex> program word | W <rd dec> <data hex> writeback in order
# R <reg dec> <value hex> final register after halt
I 00c00093  # addi x1, x0, 12
I 00a00113  # addi x2, x0, 10
I 002081b3  # add  x3, x1, x2    fwd from ex/mem and mem/wb
I 40118233  # sub  x4, x3, x1
I 0041f2b3  # and  x5, x3, x4
I 0012e333  # or   x6, x5, x1
I 403103b3  # sub  x7, x2, x3    negative result
I 00208033  # add  x0, x1, x2    x0 stays zero
I 00100433  # add  x8, x0, x1
I 00702423  # sw   x7, 8(x0)
I 00802483  # lw   x9, 8(x0)
I 00248533  # add  x10, x9, x2   load-use stall
I 00300893  # addi x17, x0, 3
I 00000073  # ecall              no halt
I 00488593  # addi x11, x17, 4
I 00a00893  # addi x17, x0, 10
I 00000073  # ecall              halt
I 06300613  # addi x12, x0, 99   never retires
W 1 0000000c
W 2 0000000a
W 3 00000016
W 4 0000000a
W 5 00000002
W 6 0000000e
W 7 fffffff4
W 8 0000000c
W 9 fffffff4
W 10 fffffffe
W 17 00000003
W 11 00000007
W 17 0000000a
R 0 00000000
R 1 0000000c
R 3 00000016
R 4 0000000a
R 5 00000002
R 6 0000000e
R 7 fffffff4
R 8 0000000c
R 9 fffffff4
R 10 fffffffe
R 11 00000007
R 12 00000000
R 17 0000000a

//--- pipelined_cpu.f
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/pipelined_cpu.sv
verif/tb_pipelined_cpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_pipelined_cpu -f pipelined_cpu.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
